// ==== cmdPkg.sv ====
`default_nettype none

package cmdPkg;

  // raw command word geometry
  localparam int cmdWidth = 32;
  localparam int regNumW = 4;
  localparam logic [regNumW-1:0] ipRegNum = 4'd15;

  // slot order inside the register number nibbles, flag bits and modifier pairs
  localparam int slotSrc1 = 0;
  localparam int slotSrc0 = 1;
  localparam int slotDst = 2;
  localparam int slotCond = 3;
  localparam int ptrLsb = 16;
  localparam int modLsb = 20;
  localparam int opLsb = 28;

  // operand modifiers
  localparam logic [1:0] modPlain = 2'b00;
  localparam logic [1:0] modPostInc = 2'b01;
  localparam logic [1:0] modPostDec = 2'b10;
  localparam logic [1:0] modAbsent = 2'b11;

  // top nibble of the command
  typedef enum logic [3:0] {
    opAdd = 4'd0,
    opSub = 4'd1,
    opAnd = 4'd2,
    opOr  = 4'd3,
    opXor = 4'd4,
    opShl = 4'd5,
    opShr = 4'd6,
    opMov = 4'd7
  } aluOp_t;

  typedef struct packed {
    logic [regNumW-1:0] regNum;
    logic isPtr;
    logic [1:0] modifier;
  } operandRef_t;

  typedef struct packed {
    aluOp_t op;
    operandRef_t cond;
    operandRef_t src1;
    operandRef_t src0;
    operandRef_t dst;
  } cmdFields_t;

endpackage

`default_nettype wire

// ==== seqPkg.sv ====
`default_nettype none

package seqPkg;

  // datapath sizes
  localparam int dataW = 32;
  localparam int memAddrW = 8;
  localparam int memDepth = 1 << memAddrW;
  localparam int regCount = 16;
  localparam int stateW = 5;

  // sequencer states, read states paired with their pointer follow-ups
  typedef enum logic [stateW-1:0] {
    waitForStart,
    preExecute,
    writeRegIp,
    readCond,
    readCondP,
    readSrc1,
    readSrc1P,
    readSrc0,
    readSrc0P,
    aluBegin,
    aluResults,
    writePrep,
    writeDst,
    writeSrc1,
    writeSrc0,
    finishBegin
  } seqState_t;

endpackage

`default_nettype wire

// ==== commandDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module commandDecoder import cmdPkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic cmdStart,
  input  logic [cmdWidth-1:0] cmdWord,
  input  logic busy,
  output cmdFields_t fields,
  output logic launch
);

  logic accept;

  // one operand slot out of the raw word
  function automatic operandRef_t sliceRef(input logic [cmdWidth-1:0] word, input int slot);
    operandRef_t opnd;
    opnd.regNum = word[slot*regNumW +: regNumW];
    opnd.isPtr = word[ptrLsb + slot];
    opnd.modifier = word[modLsb + 2*slot +: 2];
    return opnd;
  endfunction

  // starts arriving mid-command are dropped
  assign accept = cmdStart && !busy;

  // fields hold until the next accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      fields.op <= aluOp_t'(cmdWord[opLsb +: 4]);
      fields.cond <= sliceRef(cmdWord, slotCond);
      fields.src1 <= sliceRef(cmdWord, slotSrc1);
      fields.src0 <= sliceRef(cmdWord, slotSrc0);
      fields.dst <= sliceRef(cmdWord, slotDst);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      launch <= 1'b0;
    end else begin
      launch <= accept;
    end
  end

  // busy covers the launch cycle so launches never come back to back
  assert property (@(posedge clk) disable iff (rst) launch |=> !launch);

endmodule

`default_nettype wire

// ==== stateManager.sv ====
`timescale 1ns/1ns
`default_nettype none

module stateManager import cmdPkg::*, seqPkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic launch,
  input  cmdFields_t fields,
  input  logic [dataW-1:0] condValue,
  output seqState_t state,
  output logic busy,
  output logic done
);

  seqState_t nextState;
  seqState_t afterIp;
  seqState_t afterCond;
  seqState_t afterSrc1;
  seqState_t wbAfterDst;
  seqState_t wbAfterSrc1;
  logic ipOwned;
  logic dstHitsSrc1;
  logic dstHitsSrc0;
  logic wrSrc1;
  logic wrSrc0;

  function automatic logic isPresent(input operandRef_t opnd);
    return opnd.modifier != modAbsent;
  endfunction

  // post-increment or post-decrement
  function automatic logic isModified(input operandRef_t opnd);
    return !(opnd.modifier == modPlain || opnd.modifier == modAbsent);
  endfunction

  // command writes r15 itself and takes no automatic ip step
  assign ipOwned = (isPresent(fields.dst) && fields.dst.regNum == ipRegNum)
                || (isModified(fields.src1) && fields.src1.regNum == ipRegNum)
                || (isModified(fields.src0) && fields.src0.regNum == ipRegNum);

  // a direct destination wins over a source write-back to the same register
  assign dstHitsSrc1 = isPresent(fields.dst) && !fields.dst.isPtr
                    && fields.dst.regNum == fields.src1.regNum;
  assign dstHitsSrc0 = isPresent(fields.dst) && !fields.dst.isPtr
                    && fields.dst.regNum == fields.src0.regNum;
  // src0 alone writes a register named by both sources
  assign wrSrc1 = isModified(fields.src1) && !dstHitsSrc1
               && !(isModified(fields.src0) && fields.src0.regNum == fields.src1.regNum);
  assign wrSrc0 = isModified(fields.src0) && !dstHitsSrc0;

  // skip chains over absent operands
  assign afterSrc1 = isPresent(fields.src0) ? readSrc0 : aluBegin;
  assign afterCond = isPresent(fields.src1) ? readSrc1 : afterSrc1;
  assign afterIp = isPresent(fields.cond) ? readCond : afterCond;
  assign wbAfterSrc1 = wrSrc0 ? writeSrc0 : finishBegin;
  assign wbAfterDst = wrSrc1 ? writeSrc1 : wbAfterSrc1;

  always_comb begin
    case (state)
      waitForStart: nextState = launch ? preExecute : waitForStart;
      preExecute:   nextState = ipOwned ? afterIp : writeRegIp;
      writeRegIp:   nextState = afterIp;
      readCond:     nextState = fields.cond.isPtr ? readCondP : afterCond;
      readCondP:    nextState = afterCond;
      readSrc1:     nextState = fields.src1.isPtr ? readSrc1P : afterSrc1;
      readSrc1P:    nextState = afterSrc1;
      readSrc0:     nextState = fields.src0.isPtr ? readSrc0P : aluBegin;
      readSrc0P:    nextState = aluBegin;
      // condition latch is settled by now and zero skips all write-back
      aluBegin: begin
        if (isPresent(fields.cond) && condValue == '0) begin
          nextState = finishBegin;
        end else begin
          nextState = aluResults;
        end
      end
      aluResults:   nextState = writePrep;
      writePrep:    nextState = isPresent(fields.dst) ? writeDst : wbAfterDst;
      writeDst:     nextState = wbAfterDst;
      writeSrc1:    nextState = wbAfterSrc1;
      writeSrc0:    nextState = finishBegin;
      default:      nextState = waitForStart;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= waitForStart;
    end else begin
      state <= nextState;
    end
  end

  // launch cycle counts as busy so a second start is refused
  assign busy = launch || (state != waitForStart);
  // last cycle of the command
  assign done = (state == finishBegin);

  // a launch arriving mid-command would be lost
  assert property (@(posedge clk) disable iff (rst) launch |-> state == waitForStart);

  // decoded fields hold still for the whole command
  assert property (@(posedge clk) disable iff (rst)
    state != waitForStart |-> $stable(fields));

endmodule

`default_nettype wire

// ==== operandDatapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module operandDatapath import cmdPkg::*, seqPkg::*; (
  input  logic clk,
  input  logic rst,
  input  seqState_t state,
  input  cmdFields_t fields,
  input  logic memWe,
  input  logic [memAddrW-1:0] memAddr,
  input  logic [dataW-1:0] memWdata,
  output logic [dataW-1:0] memRdata,
  output logic [dataW-1:0] condValue
);

  logic [dataW-1:0] regFile [regCount];
  logic [dataW-1:0] dataMem [memDepth];
  logic [dataW-1:0] condLatch;
  logic [dataW-1:0] src1Latch;
  logic [dataW-1:0] src0Latch;
  logic [dataW-1:0] resultLatch;
  logic [dataW-1:0] aluOut;
  logic [dataW-1:0] src1Next;
  logic [dataW-1:0] src0Next;
  logic [memAddrW-1:0] dstAddr;

  function automatic logic [dataW-1:0] stepValue(input logic [dataW-1:0] value,
                                                 input logic [1:0] modifier);
    case (modifier)
      modPostInc: return value + 1'b1;
      modPostDec: return value - 1'b1;
      default:    return value;
    endcase
  endfunction

  // register value after its modifier, for source write-back
  assign src1Next = stepValue(regFile[fields.src1.regNum], fields.src1.modifier);
  assign src0Next = stepValue(regFile[fields.src0.regNum], fields.src0.modifier);

  always_comb begin
    case (fields.op)
      opAdd:   aluOut = src1Latch + src0Latch;
      opSub:   aluOut = src1Latch - src0Latch;
      opAnd:   aluOut = src1Latch & src0Latch;
      opOr:    aluOut = src1Latch | src0Latch;
      opXor:   aluOut = src1Latch ^ src0Latch;
      // shift amount from low bits of src0
      opShl:   aluOut = src1Latch << src0Latch[$clog2(dataW)-1:0];
      opShr:   aluOut = src1Latch >> src0Latch[$clog2(dataW)-1:0];
      default: aluOut = src1Latch;
    endcase
  end

  // operand latches, pointer states dereference what the read state caught
  always_ff @(posedge clk) begin
    case (state)
      readCond:   condLatch <= regFile[fields.cond.regNum];
      readCondP:  condLatch <= dataMem[condLatch[memAddrW-1:0]];
      readSrc1:   src1Latch <= regFile[fields.src1.regNum];
      readSrc1P:  src1Latch <= dataMem[src1Latch[memAddrW-1:0]];
      readSrc0:   src0Latch <= regFile[fields.src0.regNum];
      readSrc0P:  src0Latch <= dataMem[src0Latch[memAddrW-1:0]];
      aluBegin:   resultLatch <= aluOut;
      aluResults: dstAddr <= regFile[fields.dst.regNum][memAddrW-1:0];
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < regCount; i++) begin
        regFile[i] <= '0;
      end
    end else begin
      case (state)
        writeRegIp: regFile[ipRegNum] <= regFile[ipRegNum] + 1'b1;
        writeDst: begin
          if (!fields.dst.isPtr) begin
            regFile[fields.dst.regNum] <= resultLatch;
          end
        end
        writeSrc1: regFile[fields.src1.regNum] <= src1Next;
        writeSrc0: regFile[fields.src0.regNum] <= src0Next;
        default: ;
      endcase
    end
  end

  // host port only while idle
  always_ff @(posedge clk) begin
    if (state == waitForStart && memWe) begin
      dataMem[memAddr] <= memWdata;
    end else if (state == writeDst && fields.dst.isPtr) begin
      dataMem[dstAddr] <= resultLatch;
    end
  end

  assign memRdata = dataMem[memAddr];
  assign condValue = condLatch;

  assert property (@(posedge clk) disable iff (rst) memWe |-> state == waitForStart);

endmodule

`default_nettype wire

// ==== execCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module execCore import cmdPkg::*, seqPkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic cmdStart,
  input  logic [cmdWidth-1:0] cmdWord,
  input  logic memWe,
  input  logic [memAddrW-1:0] memAddr,
  input  logic [dataW-1:0] memWdata,
  output logic [dataW-1:0] memRdata,
  output logic busy,
  output logic done
);

  cmdFields_t fields;
  logic launch;
  seqState_t state;
  logic [dataW-1:0] condValue;

  // decode, then sequence, then datapath
  commandDecoder commandDecoder_i (
    .clk(clk), .rst(rst), .cmdStart(cmdStart), .cmdWord(cmdWord),
    .busy(busy), .fields(fields), .launch(launch)
  );

  stateManager stateManager_i (
    .clk(clk), .rst(rst), .launch(launch), .fields(fields),
    .condValue(condValue), .state(state), .busy(busy), .done(done)
  );

  operandDatapath operandDatapath_i (
    .clk(clk), .rst(rst), .state(state), .fields(fields), .memWe(memWe),
    .memAddr(memAddr), .memWdata(memWdata), .memRdata(memRdata), .condValue(condValue)
  );

endmodule

`default_nettype wire

// ==== tb_execCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_execCore import cmdPkg::*, seqPkg::*; ();

  // cycles a single command may take before done
  localparam int doneWait = 20;
  localparam int nameW = 8 * 16;

  logic clk;
  logic rst;
  logic cmdStart;
  logic [cmdWidth-1:0] cmdWord;
  logic memWe;
  logic [memAddrW-1:0] memAddr;
  logic [dataW-1:0] memWdata;
  logic [dataW-1:0] memRdata;
  logic busy;
  logic done;

  // parsed trace, one entry per line
  logic [7:0] kindQ [$];
  logic [nameW-1:0] nameQ [$];
  logic [memAddrW-1:0] addrQ [$];
  logic [dataW-1:0] valueQ [$];

  logic [nameW-1:0] lastName;
  logic stopped;
  int errors;
  int checks;
  int numCmds;
  int cycleCount;
  int cycleLimit;

  execCore execCore_i (
    .clk(clk), .rst(rst), .cmdStart(cmdStart), .cmdWord(cmdWord),
    .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata), .memRdata(memRdata),
    .busy(busy), .done(done)
  );

  always #20 clk = ~clk;

  // run limit from the number of commands
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      errors++;
      $display("run did not finish within %0d cycles", cycleLimit);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic checkValue(input logic [nameW-1:0] testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch %0s: expected %h, actual %h", testName, expected, actual);
    end
  endtask

  task automatic readTrace();
    int fd;
    int got;
    logic [63:0] tok;
    logic [8*80-1:0] rest;
    logic [nameW-1:0] name;
    logic [memAddrW-1:0] addr;
    logic [dataW-1:0] value;
    fd = $fopen("execTrace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open execTrace.txt");
    end else begin
      while (!$feof(fd)) begin
        tok = '0;
        name = '0;
        addr = '0;
        got = $fscanf(fd, "%s", tok);
        if (got == 1 && tok[7:0] == "#") begin
          got = $fgets(rest, fd);
        end else if (got == 1) begin
          // c lines carry a name, p and e lines an address
          if (tok[7:0] == "c") begin
            got = $fscanf(fd, "%s %h", name, value);
            numCmds++;
          end else begin
            got = $fscanf(fd, "%h %h", addr, value);
          end
          kindQ.push_back(tok[7:0]);
          nameQ.push_back(name);
          addrQ.push_back(addr);
          valueQ.push_back(value);
        end
      end
      $fclose(fd);
    end
  endtask

  // host write while idle
  task automatic preload(input logic [memAddrW-1:0] addr, input logic [dataW-1:0] data);
    memWe = 1'b1;
    memAddr = addr;
    memWdata = data;
    @(negedge clk);
    memWe = 1'b0;
    checkValue("done quiet early", 32'd0, 32'(done));
  endtask

  task automatic runCommand(input logic [nameW-1:0] testName, input logic [cmdWidth-1:0] word);
    int waited;
    lastName = testName;
    cmdStart = 1'b1;
    cmdWord = word;
    @(negedge clk);
    // launch cycle, core already busy
    checkValue(testName, 32'd1, 32'(busy));
    // inverted word offered mid-command, must be dropped
    cmdWord = ~word;
    @(negedge clk);
    cmdStart = 1'b0;
    waited = 2;
    while (!done && waited < doneWait) begin
      @(negedge clk);
      waited++;
    end
    if (done) begin
      @(negedge clk);
    end else begin
      errors++;
      stopped = 1'b1;
      $display("command %0s gave no done within %0d cycles", testName, doneWait);
    end
  endtask

  // combinational read port, sampled a cycle later
  task automatic expectWord(input logic [memAddrW-1:0] addr, input logic [dataW-1:0] value);
    memAddr = addr;
    @(negedge clk);
    checkValue(lastName, value, memRdata);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    cmdStart = 1'b0;
    cmdWord = '0;
    memWe = 1'b0;
    memAddr = '0;
    memWdata = '0;
    lastName = '0;
    stopped = 1'b0;
    errors = 0;
    checks = 0;
    numCmds = 0;
    cycleCount = 0;
    cycleLimit = 50;
    readTrace();
    cycleLimit = doneWait * numCmds + 50;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    // idle after reset
    checkValue("reset idle check", 32'd0, 32'(busy));
    checkValue("reset idle check", 32'd0, 32'(done));
    for (int i = 0; i < kindQ.size() && !stopped; i++) begin
      case (kindQ[i])
        "p": preload(addrQ[i], valueQ[i]);
        "c": runCommand(nameQ[i], valueQ[i]);
        "e": expectWord(addrQ[i], valueQ[i]);
        default: ;
      endcase
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== execTrace.txt ====
# p <addr> <data> preload, c <name> <word> command, e <addr> <value> expected word
# numbers in hex, e lines compare memory after the latest done
p 00 00000020
p 01 00000111
p 02 00002220
p 03 00030003
c ldPtr 7cd10100
c sumWalk 0c420202
c sumWalk 0c420202
c sumWalk 0c420202
c sumStore 7cc40102
e 20 00032334
c condZero 70c49100
e 20 00032334
c condPtr 70cc1100
e 20 00000004
c aluAdd 0c000512
c aluSub 1c000505
c aluShl 5c000505
c aluOr 3c000515
c aluStore 7cc40105
e 20 00323520
c aluXor 4c000525
c aluShr 6c000505
c aluAnd 2c000525
c aluMov 7cc40105
e 20 00030120
c sameReg 0c900700
c decStore 7cc40100
e 20 00000003
c ipStore 7cc4010f
e 20 00000013
c ipOwned 7cd0080f
c ipStore2 7cc4010f
e 20 00000015

// ==== tb.f ====
cmdPkg.sv
seqPkg.sv
commandDecoder.sv
stateManager.sv
operandDatapath.sv
execCore.sv
tb_execCore.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= tb_execCore
BIN := obj_dir/VtbExecCore
SRCS := $(shell grep -v '^+' tb.f)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): tb.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f tb.f -o VtbExecCore

# status comes from grep on the simulator output
run: $(BIN) execTrace.txt
	./$(BIN) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
